// File: cam_regs.sv
`timescale 1ns/1ps

module cam_regs
    import ray_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        scan_busy,
    output vec3         camera_forward,
    output tile_cfg     tile,
    output logic        start
);

    logic req;
    logic cfg_we;
    logic start_pend;

    // new request, not the cycle already being acked
    assign req = wb_cyc && wb_stb && !wb_ack;

    // writes only land while the scanner is idle
    assign cfg_we = req && wb_we && !scan_busy;

    // single cycle ack, drops even if stb is still held
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // start request seen with the ack, pulse one cycle later
    always_ff @(posedge clk) begin
        if (!rst) begin
            start_pend <= 1'b0;
            start      <= 1'b0;
        end else begin
            start_pend <= cfg_we && (wb_adr == REG_CTRL) && wb_dat_w[0];
            start      <= start_pend;
        end
    end

    // camera and tile registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            camera_forward <= FWD_RESET;
            tile           <= TILE_RESET;
        end else if (cfg_we) begin
            case (wb_adr)
                REG_FWD_X:     camera_forward.x <= wb_dat_w;
                REG_FWD_Y:     camera_forward.y <= wb_dat_w;
                REG_FWD_Z:     camera_forward.z <= wb_dat_w;
                REG_TILE_ORG:  tile.origin      <= wb_dat_w;
                REG_TILE_SIZE: tile.size        <= wb_dat_w;
                default: ;
            endcase
        end
    end

    // read data latched with the ack
    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_adr)
                REG_FWD_X:     wb_dat_r <= camera_forward.x;
                REG_FWD_Y:     wb_dat_r <= camera_forward.y;
                REG_FWD_Z:     wb_dat_r <= camera_forward.z;
                REG_TILE_ORG:  wb_dat_r <= tile.origin;
                REG_TILE_SIZE: wb_dat_r <= tile.size;
                // status, busy in bit 0
                REG_CTRL:      wb_dat_r <= {31'd0, scan_busy};
                default:       wb_dat_r <= '0;
            endcase
        end
    end

endmodule

// File: inv_sqrt.sv
`timescale 1ns/1ps

module inv_sqrt
    import ray_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  fp    x,
    output logic valid_out,
    output fp    inv_sqrt
);

    logic [30:0] x_mag;
    logic [4:0]  msb;
    logic [4:0]  msb_even;
    logic [5:0]  seed_idx;
    logic [31:0] y_fin;

    // mantissa m in q2.30, range [1,4)
    logic [31:0] m_s1;
    logic [31:0] m_s2;
    logic [31:0] m_s3;
    // half exponent, result is y >> (he - 6)
    logic [3:0]  he_s1;
    logic [3:0]  he_s2;
    logic [3:0]  he_s3;
    logic [16:0] seed_s2;
    logic [31:0] y_s3;
    logic        valid_s1;
    logic        valid_s2;
    logic        valid_s3;

    // index of the highest set bit
    function automatic logic [4:0] lead_one(logic [30:0] v);
        logic [4:0] pos;
        pos = '0;
        for (int i = 0; i < 31; i++) begin
            if (v[i]) begin
                pos = 5'(i);
            end
        end
        return pos;
    endfunction

    // y * (3 - m*y^2) / 2, y and m both q.30
    function automatic logic [31:0] newton_step(logic [31:0] y, logic [31:0] m);
        logic [63:0] sq;
        logic [63:0] t_full;
        logic [32:0] h;
        logic [64:0] prod;
        sq     = y * y;
        t_full = m * sq[61:30];
        // 3.0 in q.30
        h      = 33'h0_C000_0000 - {1'b0, t_full[61:30]};
        prod   = y * h;
        return prod[62:31];
    endfunction

    // negative input treated as zero, saturates at the end
    always_comb begin
        x_mag    = x[31] ? '0 : x[30:0];
        msb      = lead_one(x_mag);
        msb_even = {msb[4:1], 1'b0};
    end

    // stage 1, even shift puts the leading one at bit 30 or 31
    always_ff @(posedge clk) begin
        m_s1  <= {1'b0, x_mag} << (5'd30 - msb_even);
        he_s1 <= msb[4:1];
    end

    // [1,2) uses 1/32 bins, [2,4) uses 1/16 bins
    assign seed_idx = m_s1[31] ? {1'b1, m_s1[30:26]} : {1'b0, m_s1[29:25]};

    // stage 2, seed lookup
    always_ff @(posedge clk) begin
        seed_s2 <= INV_SQRT_SEED[seed_idx];
        m_s2    <= m_s1;
        he_s2   <= he_s1;
    end

    // stage 3, first refinement from q1.16 seed
    always_ff @(posedge clk) begin
        y_s3  <= newton_step({1'b0, seed_s2, 14'd0}, m_s2);
        m_s3  <= m_s2;
        he_s3 <= he_s2;
    end

    assign y_fin = newton_step(y_s3, m_s3);

    // stage 4, second refinement and exponent shift back to q8.24
    always_ff @(posedge clk) begin
        if (he_s3 < 4'd6) begin
            // x below 2^-12, result would overflow
            inv_sqrt <= FP_MAX;
        end else begin
            inv_sqrt <= fp'(y_fin >> (he_s3 - 4'd6));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            valid_s3  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_s1  <= valid_in;
            valid_s2  <= valid_s1;
            valid_s3  <= valid_s2;
            valid_out <= valid_s3;
        end
    end

endmodule

// File: pixel_scanner.sv
`timescale 1ns/1ps

module pixel_scanner
    import ray_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  tile_cfg tile,
    output pixel_xy pixel,
    output logic    pixel_valid,
    output logic    busy
);

    logic [15:0] room_x;
    logic [15:0] room_y;
    logic [15:0] span_x;
    logic [15:0] span_y;
    logic [15:0] cnt_x;
    logic [15:0] cnt_y;
    logic        last_x;
    logic        last_y;

    // visible part of the tile after clipping at the screen edge
    always_comb begin
        room_x = (tile.origin.x < SCREEN_WIDTH) ? SCREEN_WIDTH - tile.origin.x : 16'd0;
        room_y = (tile.origin.y < SCREEN_HEIGHT) ? SCREEN_HEIGHT - tile.origin.y : 16'd0;
        span_x = (tile.size.x < room_x) ? tile.size.x : room_x;
        span_y = (tile.size.y < room_y) ? tile.size.y : room_y;
    end

    assign last_x = (cnt_x == span_x - 16'd1);
    assign last_y = (cnt_y == span_y - 16'd1);

    // raster walk, x fastest
    always_ff @(posedge clk) begin
        if (!rst) begin
            pixel_valid <= 1'b0;
            cnt_x       <= '0;
            cnt_y       <= '0;
        end else if (pixel_valid) begin
            if (last_x) begin
                cnt_x <= '0;
                if (last_y) begin
                    pixel_valid <= 1'b0;
                end else begin
                    cnt_y <= cnt_y + 16'd1;
                end
            end else begin
                cnt_x <= cnt_x + 16'd1;
            end
        end else if (start && (span_x != 16'd0) && (span_y != 16'd0)) begin
            // empty tile never gets here
            pixel_valid <= 1'b1;
            cnt_x       <= '0;
            cnt_y       <= '0;
        end
    end

    // absolute screen coordinates
    assign pixel.x = tile.origin.x + cnt_x;
    assign pixel.y = tile.origin.y + cnt_y;

    // high from start until the cycle after the last pixel
    assign busy = start || pixel_valid;

endmodule

// File: ray_generator.sv
`timescale 1ns/1ps

module ray_generator
    import ray_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  pixel_xy pixel,
    input  logic    pixel_valid,
    input  vec3     camera_forward,
    output vec3     ray_direction,
    output pixel_xy ray_pixel,
    output logic    ray_valid
);

    // unnormalized ray with its pixel, waits out inv_sqrt
    typedef struct packed {
        vec3     ray;
        pixel_xy pix;
    } ray_tag_t;

    fp        ndc_x;
    fp        ndc_y;
    pixel_xy  pix_s1;
    vec3      ray_s2;
    pixel_xy  pix_s2;
    vec3      ray_s3;
    pixel_xy  pix_s3;
    fp        mag_sq;
    logic     valid_s1;
    logic     valid_s2;
    logic     valid_s3;
    logic     inv_valid;
    fp        inv_mag;
    ray_tag_t tag_dly [INV_SQRT_LATENCY];
    ray_tag_t tag_out;

    // (p + 0.5) * scale, centre held in q16.24 since p exceeds q8.24 range
    function automatic fp pix_to_unit(logic [15:0] p, fp scale);
        logic signed [40:0] centre;
        logic signed [72:0] prod;
        centre = $signed({1'b0, p, 24'd0}) + FP_HALF;
        prod   = centre * scale;
        return prod[55:24];
    endfunction

    // stage 1, pixel centre to ndc in [-1,1]
    // y flipped so row 0 is the top of the screen
    always_ff @(posedge clk) begin
        ndc_x  <= pix_to_unit(pixel.x, SCALE_X) - FP_ONE;
        ndc_y  <= FP_ONE - pix_to_unit(pixel.y, SCALE_Y);
        pix_s1 <= pixel;
    end

    // stage 2, right*ndc_x + up*ndc_y - forward
    always_ff @(posedge clk) begin
        ray_s2.x <= fp_mul(ndc_x, CAM_RIGHT.x) + fp_mul(ndc_y, CAM_UP.x) - camera_forward.x;
        ray_s2.y <= fp_mul(ndc_x, CAM_RIGHT.y) + fp_mul(ndc_y, CAM_UP.y) - camera_forward.y;
        ray_s2.z <= fp_mul(ndc_x, CAM_RIGHT.z) + fp_mul(ndc_y, CAM_UP.z) - camera_forward.z;
        pix_s2   <= pix_s1;
    end

    // stage 3, squared length
    always_ff @(posedge clk) begin
        mag_sq <= vec3_dot(ray_s2, ray_s2);
        ray_s3 <= ray_s2;
        pix_s3 <= pix_s2;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
        end else begin
            valid_s1 <= pixel_valid;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
        end
    end

    inv_sqrt inv_sqrt_i (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_s3),
        .x         (mag_sq),
        .valid_out (inv_valid),
        .inv_sqrt  (inv_mag)
    );

    // delay line matches inv_sqrt depth
    // free running, pipeline never stalls
    always_ff @(posedge clk) begin
        tag_dly[0] <= '{ray: ray_s3, pix: pix_s3};
        for (int i = 1; i < INV_SQRT_LATENCY; i++) begin
            tag_dly[i] <= tag_dly[i-1];
        end
    end

    // same ray that produced inv_mag
    assign tag_out = tag_dly[INV_SQRT_LATENCY-1];

    // normalize
    always_ff @(posedge clk) begin
        ray_direction.x <= fp_mul(tag_out.ray.x, inv_mag);
        ray_direction.y <= fp_mul(tag_out.ray.y, inv_mag);
        ray_direction.z <= fp_mul(tag_out.ray.z, inv_mag);
        ray_pixel       <= tag_out.pix;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ray_valid <= 1'b0;
        end else begin
            ray_valid <= inv_valid;
        end
    end

endmodule

// File: ray_pkg.sv
package ray_pkg;

    // signed q8.24 fixed point
    typedef logic signed [31:0] fp;

    localparam fp FP_ONE  = 32'h0100_0000;
    localparam fp FP_HALF = 32'h0080_0000;
    // saturation value for out of range results
    localparam fp FP_MAX  = 32'h7FFF_FFFF;

    typedef struct packed {
        fp x;
        fp y;
        fp z;
    } vec3;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
    } pixel_xy;

    typedef struct packed {
        pixel_xy origin;
        pixel_xy size;
    } tile_cfg;

    localparam logic [15:0] SCREEN_WIDTH  = 16'd640;
    localparam logic [15:0] SCREEN_HEIGHT = 16'd480;

    // 2/640 and 2/480, rounded to nearest
    localparam fp SCALE_X = 32'h0000_CCCD;
    localparam fp SCALE_Y = 32'h0001_1111;

    // fixed camera basis, looking down -z
    localparam vec3 CAM_RIGHT = '{x: FP_ONE, y: '0, z: '0};
    localparam vec3 CAM_UP    = '{x: '0, y: FP_ONE, z: '0};

    // register reset values
    localparam vec3     FWD_RESET  = '{x: '0, y: '0, z: FP_ONE};
    localparam tile_cfg TILE_RESET = '{origin: '{x: 16'd0, y: 16'd0},
                                       size:   '{x: 16'd1, y: 16'd1}};

    // cycles through inv_sqrt
    localparam int INV_SQRT_LATENCY = 4;

    // wishbone word addresses
    localparam logic [2:0] REG_FWD_X     = 3'd0;
    localparam logic [2:0] REG_FWD_Y     = 3'd1;
    localparam logic [2:0] REG_FWD_Z     = 3'd2;
    localparam logic [2:0] REG_TILE_ORG  = 3'd3;
    localparam logic [2:0] REG_TILE_SIZE = 3'd4;
    localparam logic [2:0] REG_CTRL      = 3'd5;

    // inverse square root seeds, q1.16
    typedef logic [63:0][16:0] seed_tab_t;

    // entries 0..31 cover m in [1,2), 32..63 cover [2,4)
    // each entry is 1/sqrt of its bin midpoint, found by bisection
    function automatic seed_tab_t build_seed_tab();
        seed_tab_t tab;
        longint unsigned m_mid;
        longint unsigned y;
        longint unsigned trial;
        int i;
        int b;
        for (i = 0; i < 64; i++) begin
            // midpoint in q2.14
            if (i < 32) begin
                m_mid = 64'(65 + 2 * i) << 8;
            end else begin
                m_mid = 64'(65 + 2 * (i - 32)) << 9;
            end
            y = 0;
            for (b = 16; b >= 0; b--) begin
                trial = y | (64'd1 << b);
                // y^2 * m <= 1 with q.32 times q.14
                if (trial * trial * m_mid <= (64'd1 << 46)) begin
                    y = trial;
                end
            end
            tab[i] = 17'(y);
        end
        return tab;
    endfunction

    localparam seed_tab_t INV_SQRT_SEED = build_seed_tab();

    // product rounded toward negative infinity
    function automatic fp fp_mul(fp a, fp b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[55:24];
    endfunction

    function automatic fp vec3_dot(vec3 a, vec3 b);
        return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
    endfunction

endpackage

// File: ray_unit_top.sv
`timescale 1ns/1ps

module ray_unit_top
    import ray_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output vec3         ray_direction,
    output pixel_xy     ray_pixel,
    output logic        ray_valid
);

    vec3     camera_forward;
    tile_cfg tile;
    logic    start;
    logic    scan_busy;
    pixel_xy pixel;
    logic    pixel_valid;

    // host registers
    cam_regs cam_regs_i (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .scan_busy      (scan_busy),
        .camera_forward (camera_forward),
        .tile           (tile),
        .start          (start)
    );

    // one pixel per clock over the tile
    pixel_scanner pixel_scanner_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .tile        (tile),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .busy        (scan_busy)
    );

    // 8 cycle ray pipeline
    ray_generator ray_generator_i (
        .clk            (clk),
        .rst            (rst),
        .pixel          (pixel),
        .pixel_valid    (pixel_valid),
        .camera_forward (camera_forward),
        .ray_direction  (ray_direction),
        .ray_pixel      (ray_pixel),
        .ray_valid      (ray_valid)
    );

endmodule

// File: sim.f
ray_pkg.sv
cam_regs.sv
pixel_scanner.sv
inv_sqrt.sv
ray_generator.sv
ray_unit_top.sv
tb_ray_unit_sva.sv
tb_ray_unit.sv

// File: tb_ray_unit.sv
`timescale 1ns/1ps

module tb_ray_unit
    import ray_pkg::*;
();

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    vec3         ray_direction;
    pixel_xy     ray_pixel;
    logic        ray_valid;

    // captured rays and the expected pixel order
    vec3     got_dir [$];
    pixel_xy got_pix [$];
    pixel_xy exp_pix [$];
    // configuration the model works from
    vec3     cur_fwd;
    tile_cfg cur_tile;
    int      errors;
    int      err_mark;
    int      test_num;
    int      tests_passed;
    int      tests_failed;

    ray_unit_top ray_unit_top_i (.*);

    always #10 clk = ~clk;

    // outputs are registered, sample mid cycle
    always @(negedge clk) begin
        if (rst && ray_valid) begin
            got_dir.push_back(ray_direction);
            got_pix.push_back(ray_pixel);
        end
    end

    function automatic real fp_to_real(fp v);
        return $itor(v) / 16777216.0;
    endfunction

    // one classic cycle, held until ack
    // with linger, stb stays up one more cycle and ack must drop
    task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                            input bit linger, output logic [31:0] rdata);
        int n;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!wb_ack && n < 16);
        if (!wb_ack) begin
            $display("timeout: no wb_ack for register %0d at t=%0t", adr, $time);
            errors++;
        end
        rdata = wb_dat_r;
        if (linger) begin
            @(posedge clk);
            #2;
            if (wb_ack !== 1'b0) begin
                $display("ERROR t=%0t wb_ack with stb held: expected 0 got %b", $time, wb_ack);
                errors++;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, data, 1'b0, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_cycle(1'b0, adr, '0, 1'b0, data);
    endtask

    // poll status register until busy matches
    task automatic wait_busy_is(input logic level);
        logic [31:0] st;
        int n;
        n = 0;
        do begin
            wb_read(REG_CTRL, st);
            n++;
        end while (st[0] !== level && n < 500);
        if (st[0] !== level) begin
            $display("timeout: busy never read as %0d", level);
            errors++;
        end
    endtask

    task automatic wait_rays(input int count);
        int n;
        n = 0;
        while (got_dir.size() < count && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (got_dir.size() < count) begin
            $display("timeout: only %0d of %0d rays arrived", got_dir.size(), count);
            errors++;
        end
        // drain, any extra ray shows up here
        repeat (12) @(posedge clk);
    endtask

    function automatic vec3 rand_fwd();
        vec3 f;
        int  zmag;
        // x and y uniform in +-2.0
        f.x  = fp'(int'($urandom_range(67108864)) - 33554432);
        f.y  = fp'(int'($urandom_range(67108864)) - 33554432);
        // |z| between 0.5 and 2.0
        zmag = int'($urandom_range(33554432, 8388608));
        f.z  = fp'(($urandom_range(1) == 1) ? -zmag : zmag);
        return f;
    endfunction

    // tile fully on screen
    function automatic tile_cfg rand_tile(int max_w, int max_h);
        tile_cfg t;
        int      w;
        int      h;
        w          = int'($urandom_range(max_w, 1));
        h          = int'($urandom_range(max_h, 1));
        t.size.x   = 16'(w);
        t.size.y   = 16'(h);
        t.origin.x = 16'($urandom_range(int'(SCREEN_WIDTH) - w));
        t.origin.y = 16'($urandom_range(int'(SCREEN_HEIGHT) - h));
        return t;
    endfunction

    task automatic program_cam(input vec3 f, input tile_cfg t);
        wb_write(REG_FWD_X, f.x);
        wb_write(REG_FWD_Y, f.y);
        wb_write(REG_FWD_Z, f.z);
        wb_write(REG_TILE_ORG, t.origin);
        wb_write(REG_TILE_SIZE, t.size);
        cur_fwd  = f;
        cur_tile = t;
    endtask

    // visible pixels of a tile, raster order
    task automatic add_expected(input tile_cfg t);
        int      w;
        int      h;
        pixel_xy p;
        w = int'(SCREEN_WIDTH) - int'(t.origin.x);
        h = int'(SCREEN_HEIGHT) - int'(t.origin.y);
        if (w < 0) w = 0;
        if (h < 0) h = 0;
        if (int'(t.size.x) < w) w = t.size.x;
        if (int'(t.size.y) < h) h = t.size.y;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                p.x = 16'(int'(t.origin.x) + x);
                p.y = 16'(int'(t.origin.y) + y);
                exp_pix.push_back(p);
            end
        end
    endtask

    task automatic check_comp(input string name, input pixel_xy p, input real want, input fp got);
        real diff;
        diff = fp_to_real(got) - want;
        if (diff > 1.0 / 4096.0 || diff < -1.0 / 4096.0) begin
            $display("ERROR t=%0t %s at pixel (%0d,%0d): expected %f got %f",
                     $time, name, p.x, p.y, want, fp_to_real(got));
            errors++;
        end
    endtask

    // compare captured rays with the real-number model
    task automatic check_rays();
        int  n;
        real nx;
        real ny;
        real rx;
        real ry;
        real rz;
        real len;
        n = exp_pix.size();
        if (got_dir.size() != n) begin
            $display("ERROR t=%0t ray count: expected %0d got %0d", $time, n, got_dir.size());
            errors++;
        end
        if (got_dir.size() < n) n = got_dir.size();
        for (int i = 0; i < n; i++) begin
            if (got_pix[i] != exp_pix[i]) begin
                $display("ERROR t=%0t ray_pixel[%0d]: expected (%0d,%0d) got (%0d,%0d)", $time,
                         i, exp_pix[i].x, exp_pix[i].y, got_pix[i].x, got_pix[i].y);
                errors++;
            end
            // pixel centre to ndc, row 0 at the top
            nx  = ($itor(exp_pix[i].x) + 0.5) * 2.0 / $itor(SCREEN_WIDTH) - 1.0;
            ny  = 1.0 - ($itor(exp_pix[i].y) + 0.5) * 2.0 / $itor(SCREEN_HEIGHT);
            rx  = nx - fp_to_real(cur_fwd.x);
            ry  = ny - fp_to_real(cur_fwd.y);
            rz  = -fp_to_real(cur_fwd.z);
            len = $sqrt(rx * rx + ry * ry + rz * rz);
            check_comp("ray_direction.x", exp_pix[i], rx / len, got_dir[i].x);
            check_comp("ray_direction.y", exp_pix[i], ry / len, got_dir[i].y);
            check_comp("ray_direction.z", exp_pix[i], rz / len, got_dir[i].z);
        end
    endtask

    // single scan of the programmed tile
    task automatic scan_and_check();
        exp_pix.delete();
        add_expected(cur_tile);
        got_dir.delete();
        got_pix.delete();
        wb_write(REG_CTRL, 32'd1);
        wait_rays(exp_pix.size());
        wait_busy_is(1'b0);
        check_rays();
    endtask

    task automatic check_regs(input logic [31:0] want [5]);
        logic [31:0] rd;
        for (int a = 0; a < 5; a++) begin
            wb_read(3'(a), rd);
            if (rd !== want[a]) begin
                $display("ERROR t=%0t wb_dat_r reg %0d: expected %h got %h",
                         $time, a, want[a], rd);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", test_num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic test_registers();
        logic [31:0] shadow [5];
        logic [31:0] rd;
        int          a;
        // reset values first
        shadow = '{32'd0, 32'd0, 32'h0100_0000, 32'd0, 32'h0001_0001};
        check_regs(shadow);
        // stb held past the ack, ack must still be one cycle
        repeat (12) begin
            a         = int'($urandom_range(4));
            shadow[a] = $urandom();
            wb_cycle(1'b1, 3'(a), shadow[a], 1'b1, rd);
        end
        check_regs(shadow);
        wb_read(REG_CTRL, rd);
        if (rd !== 32'd0) begin
            $display("ERROR t=%0t wb_dat_r reg 5: expected %h got %h", $time, 32'd0, rd);
            errors++;
        end
        end_test("register access");
    endtask

    task automatic clip_case(input int ox, input int oy, input int w, input int h);
        tile_cfg t;
        t.origin.x = 16'(ox);
        t.origin.y = 16'(oy);
        t.size.x   = 16'(w);
        t.size.y   = 16'(h);
        program_cam(rand_fwd(), t);
        scan_and_check();
    endtask

    task automatic test_lock();
        logic [31:0] want [5];
        tile_cfg     t;
        vec3         f_new;
        // 8x8 tile, origin drawn so it stays on screen
        t.size.x   = 16'd8;
        t.size.y   = 16'd8;
        t.origin.x = 16'($urandom_range(int'(SCREEN_WIDTH) - 8));
        t.origin.y = 16'($urandom_range(int'(SCREEN_HEIGHT) - 8));
        program_cam(rand_fwd(), t);
        exp_pix.delete();
        add_expected(cur_tile);
        got_dir.delete();
        got_pix.delete();
        wb_write(REG_CTRL, 32'd1);
        wait_busy_is(1'b1);
        // mid-scan writes, all must be dropped
        f_new = rand_fwd();
        t     = rand_tile(8, 8);
        wb_write(REG_FWD_X, f_new.x);
        wb_write(REG_FWD_Y, f_new.y);
        wb_write(REG_FWD_Z, f_new.z);
        wb_write(REG_TILE_ORG, t.origin);
        wb_write(REG_TILE_SIZE, t.size);
        wb_write(REG_CTRL, 32'd1);
        wait_rays(exp_pix.size());
        wait_busy_is(1'b0);
        check_rays();
        want = '{cur_fwd.x, cur_fwd.y, cur_fwd.z, cur_tile.origin, cur_tile.size};
        check_regs(want);
        end_test("configuration lock");
    endtask

    task automatic test_back_to_back();
        tile_cfg t;
        t.size.x   = 16'd8;
        t.size.y   = 16'd6;
        t.origin.x = 16'($urandom_range(int'(SCREEN_WIDTH) - 8));
        t.origin.y = 16'($urandom_range(int'(SCREEN_HEIGHT) - 6));
        program_cam(rand_fwd(), t);
        exp_pix.delete();
        add_expected(cur_tile);
        add_expected(cur_tile);
        got_dir.delete();
        got_pix.delete();
        wb_write(REG_CTRL, 32'd1);
        wait_busy_is(1'b1);
        wait_busy_is(1'b0);
        // restart at once, first rays still in flight
        wb_write(REG_CTRL, 32'd1);
        wait_rays(exp_pix.size());
        wait_busy_is(1'b0);
        check_rays();
        end_test("back-to-back scans");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        errors       = 0;
        err_mark     = 0;
        test_num     = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(24));
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;

        test_registers();

        repeat (20) begin
            program_cam(rand_fwd(), rand_tile(8, 8));
            scan_and_check();
        end
        end_test("ray values");

        // larger tiles for order and count
        repeat (4) begin
            program_cam(rand_fwd(), rand_tile(16, 16));
            scan_and_check();
        end
        end_test("raster order and count");

        clip_case(636, 100, 8, 4);
        clip_case(200, 477, 5, 8);
        clip_case(637, 478, 6, 6);
        clip_case(630 + int'($urandom_range(9)), 470 + int'($urandom_range(9)), 16, 16);
        end_test("clipping");

        test_lock();
        test_back_to_back();

        $display("tests passed %0d failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb_ray_unit_sva.sv
`timescale 1ns/1ps

module tb_ray_unit_sva
    import ray_pkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    wb_cyc,
    input logic    wb_stb,
    input logic    wb_ack,
    input logic    start,
    input logic    pixel_valid,
    input logic    busy,
    input logic    ray_valid,
    input tile_cfg tile,
    input vec3     camera_forward
);

    // ack is a single pulse
    ack_single: assert property (@(posedge clk) disable iff (!rst) wb_ack |=> !wb_ack)
        else $error("wb_ack high for more than one cycle");

    // ack only answers a request
    ack_after_req: assert property (@(posedge clk) disable iff (!rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding cyc and stb");

    // pipeline empty right after reset
    quiet_after_reset: assert property (@(posedge clk) $rose(rst) |-> !ray_valid [*8])
        else $error("ray_valid within 8 cycles of reset release");

    // fixed 8 cycle pipeline, both directions
    ray_latency: assert property (@(posedge clk) disable iff (!rst)
        pixel_valid |-> ##8 ray_valid)
        else $error("no ray_valid 8 cycles after pixel_valid");

    ray_source: assert property (@(posedge clk) disable iff (!rst)
        ray_valid |-> $past(pixel_valid, 8))
        else $error("ray_valid without pixel_valid 8 cycles before");

    // a pixel run only opens the cycle after a start pulse
    pixel_after_start: assert property (@(posedge clk) disable iff (!rst)
        $rose(pixel_valid) |-> $past(start))
        else $error("pixel_valid rose without a start pulse before it");

    // camera and tile frozen while the scan is busy
    cfg_locked: assert property (@(posedge clk) disable iff (!rst)
        busy |=> $stable(tile) && $stable(camera_forward))
        else $error("camera or tile changed while busy");

endmodule

bind ray_unit_top tb_ray_unit_sva tb_ray_unit_sva_i (
    .clk            (clk),
    .rst            (rst),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_ack         (wb_ack),
    .start          (start),
    .pixel_valid    (pixel_valid),
    .busy           (scan_busy),
    .ray_valid      (ray_valid),
    .tile           (tile),
    .camera_forward (camera_forward)
);
